// ==== hdl/video_consts.svh ====
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// --------------------
// horizontal raster, in pixel clocks
// --------------------

// visible pixels per line
`define H_ACTIVE 1024
// hsync drops at this count
`define H_SYNC_ON 1048
// hsync returns high at this count
`define H_SYNC_OFF 1184
// full line including blanking
`define H_TOTAL 1344

// --------------------
// vertical raster, in lines
// --------------------

// visible lines per frame
`define V_ACTIVE 768
// vsync drops on this line
`define V_SYNC_ON 777
// vsync returns high on this line
`define V_SYNC_OFF 783
// full frame including blanking
`define V_TOTAL 806

// --------------------
// frame buffer
// --------------------

// read runs this many pixels ahead of the raster to cover bank latency
`define FETCH_LEAD 8
// bits per colour in a stored pixel, three colours per pixel
`define COLOR_BITS 6

`endif

// ==== hdl/video_pkg.sv ====
`default_nettype none

package video_pkg;

`include "video_consts.svh"

   // bank access slot, set by the pixel phase
   // even counts read for display, odd counts write
   typedef enum logic {
      slot_read  = 1'b0,
      slot_write = 1'b1
   } ram_slot_e;

   // raster counters
   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;

   // bank address, line on top and word index (column / 2) below
   typedef logic [18:0] vram_addr_t;

   // one rgb pixel, red then green then blue from the msb down
   typedef logic [3*`COLOR_BITS-1:0] pixel_t;

   // one bank word holds two pixels, even column in the upper half
   typedef logic [2*3*`COLOR_BITS-1:0] vram_word_t;

endpackage

`default_nettype wire

// ==== hdl/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module raster_timing import video_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   output hcount_t hcount,
   output vcount_t vcount,
   output logic    hsync,
   output logic    vsync,
   output logic    blank
);

   // registered blank flags per axis
   logic hblank;
   logic vblank;

   // count decodes true in the last cycle before each change
   logic hreset;
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic vreset;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;

   logic next_hblank;
   logic next_vblank;

   // --------------------
   // horizontal decode
   // --------------------
   assign hreset    = (hcount == hcount_t'(`H_TOTAL - 1));
   assign hblank_on = (hcount == hcount_t'(`H_ACTIVE - 1));
   assign hsync_on  = (hcount == hcount_t'(`H_SYNC_ON - 1));
   assign hsync_off = (hcount == hcount_t'(`H_SYNC_OFF - 1));

   // --------------------
   // vertical decode
   // --------------------
   // vertical events only happen on the last pixel of a line
   assign vreset    = hreset & (vcount == vcount_t'(`V_TOTAL - 1));
   assign vblank_on = hreset & (vcount == vcount_t'(`V_ACTIVE - 1));
   assign vsync_on  = hreset & (vcount == vcount_t'(`V_SYNC_ON - 1));
   assign vsync_off = hreset & (vcount == vcount_t'(`V_SYNC_OFF - 1));

   // blank flags set at end of active region and cleared at wrap
   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         // syncs are active low and idle high
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= hreset ? '0 : hcount + 1'b1;
         if (hreset) begin
            vcount <= vreset ? '0 : vcount + 1'b1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         // next flags let blank drop with the line wrap and not a cycle later
         blank  <= next_vblank | next_hblank;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/fetch_address.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module fetch_address import video_pkg::*; (
   input  hcount_t    hcount,
   input  vcount_t    vcount,
   output ram_slot_e  slot,
   output vram_addr_t read_addr
);

   // forecast position, FETCH_LEAD pixels ahead of the raster
   logic    wrap_line;
   hcount_t hcount_f;
   vcount_t vcount_f;

   // --------------------
   // forecast column
   // --------------------
   // from the hsync point on, fetch the next line's first words
   // so the data is waiting when the next line starts
   assign wrap_line = (hcount >= hcount_t'(`H_SYNC_ON));

   always_comb begin
      if (wrap_line) begin
         hcount_f = hcount - hcount_t'(`H_SYNC_ON);
      end else begin
         hcount_f = hcount + hcount_t'(`FETCH_LEAD);
      end
   end

   // --------------------
   // forecast line
   // --------------------
   always_comb begin
      if (!wrap_line) begin
         vcount_f = vcount;
      end else if (vcount == vcount_t'(`V_TOTAL - 1)) begin
         // last line of the frame rolls over to line 0
         vcount_f = '0;
      end else begin
         vcount_f = vcount + 1'b1;
      end
   end

   // line in the upper ten bits, two pixels per word below
   assign read_addr = {vcount_f, hcount_f[9:1]};

   // even pixel counts read, odd counts are free for writes
   assign slot = hcount[0] ? slot_write : slot_read;

endmodule

`default_nettype wire

// ==== hdl/bank_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter import video_pkg::*; (
   input  ram_slot_e  slot,
   input  vram_addr_t read_addr,
   input  vram_addr_t cam_addr,
   input  vram_word_t cam_data,
   input  vram_addr_t proc_addr,
   input  vram_word_t proc_data,
   input  logic       proc_enable,
   input  logic       show_proc,
   input  vram_word_t bank0_rdata,
   input  vram_word_t bank1_rdata,
   output vram_addr_t bank0_addr,
   output logic       bank0_we,
   output vram_word_t bank0_wdata,
   output vram_addr_t bank1_addr,
   output logic       bank1_we,
   output vram_word_t bank1_wdata,
   output vram_word_t read_word
);

   // --------------------
   // bank 0, camera frame
   // --------------------
   // every write slot belongs to the camera side
   always_comb begin
      if (slot == slot_write) begin
         bank0_addr = cam_addr;
         bank0_we   = 1'b1;
      end else begin
         bank0_addr = read_addr;
         bank0_we   = 1'b0;
      end
   end

   // data bus can sit on the camera word, we decides if it lands
   assign bank0_wdata = cam_data;

   // --------------------
   // bank 1, processed frame
   // --------------------
   // writes only when the processing side is running
   // otherwise the slot falls back to a harmless display read
   always_comb begin
      if ((slot == slot_write) && proc_enable) begin
         bank1_addr = proc_addr;
         bank1_we   = 1'b1;
      end else begin
         bank1_addr = read_addr;
         bank1_we   = 1'b0;
      end
   end

   assign bank1_wdata = proc_data;

   // --------------------
   // display source
   // --------------------
   // both banks see the same read address, so either word lines up
   assign read_word = show_proc ? bank1_rdata : bank0_rdata;

endmodule

`default_nettype wire

// ==== hdl/pixel_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module pixel_unpack import video_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  ram_slot_e  slot,
   input  vram_word_t read_word,
   input  logic       hsync,
   input  logic       vsync,
   input  logic       blank,
   output logic [7:0] vga_red,
   output logic [7:0] vga_green,
   output logic [7:0] vga_blue,
   output logic       vga_hsync,
   output logic       vga_vsync,
   output logic       vga_blank
);

   // two-stage word latch
   vram_word_t word_latched;
   vram_word_t word_display;
   // pixel picked from the display word, then its output register
   pixel_t     pixel_sel;
   pixel_t     pixel_q;

   // --------------------
   // word latch
   // --------------------
   // bank data is valid in the read slot two cycles after the address
   // hand it to the display register once the write slot ends
   always_ff @(posedge clk) begin
      if (slot == slot_read) begin
         word_latched <= read_word;
      end
      if (slot == slot_write) begin
         word_display <= word_latched;
      end
   end

   // even column sits in the upper half of the word
   always_comb begin
      if (slot == slot_read) begin
         pixel_sel = word_display[2*$bits(pixel_t)-1:$bits(pixel_t)];
      end else begin
         pixel_sel = word_display[$bits(pixel_t)-1:0];
      end
   end

   // --------------------
   // output registers
   // --------------------
   always_ff @(posedge clk) begin
      pixel_q <= pixel_sel;
   end

   // sync and blank ride alongside the pixel, one cycle behind the raster
   always_ff @(posedge clk) begin
      if (reset) begin
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b0;
      end else begin
         vga_hsync <= hsync;
         vga_vsync <= vsync;
         vga_blank <= blank;
      end
   end

   // dac takes 8 bits per colour, low bits padded with zero
   assign vga_red   = {pixel_q[3*`COLOR_BITS-1:2*`COLOR_BITS], {(8-`COLOR_BITS){1'b0}}};
   assign vga_green = {pixel_q[2*`COLOR_BITS-1:`COLOR_BITS], {(8-`COLOR_BITS){1'b0}}};
   assign vga_blue  = {pixel_q[`COLOR_BITS-1:0], {(8-`COLOR_BITS){1'b0}}};

endmodule

`default_nettype wire

// ==== hdl/zbt_video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zbt_video_top import video_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   // camera side writes into bank 0
   input  vram_addr_t cam_addr,
   input  vram_word_t cam_data,
   // processed image writes into bank 1
   input  vram_addr_t proc_addr,
   input  vram_word_t proc_data,
   input  logic       proc_enable,
   input  logic       show_proc,
   // zbt bank ports
   input  vram_word_t bank0_rdata,
   input  vram_word_t bank1_rdata,
   output vram_addr_t bank0_addr,
   output logic       bank0_we,
   output vram_word_t bank0_wdata,
   output vram_addr_t bank1_addr,
   output logic       bank1_we,
   output vram_word_t bank1_wdata,
   // vga dac and syncs
   output logic [7:0] vga_red,
   output logic [7:0] vga_green,
   output logic [7:0] vga_blue,
   output logic       vga_hsync,
   output logic       vga_vsync,
   output logic       vga_blank
);

   // raster position and timing
   hcount_t    hcount;
   vcount_t    vcount;
   logic       hsync;
   logic       vsync;
   logic       blank;
   // memory slot and forecast address
   ram_slot_e  slot;
   vram_addr_t read_addr;
   // word selected for display
   vram_word_t read_word;

   // --------------------
   // raster
   // --------------------
   raster_timing raster_timing_i (
      .clk    (clk),
      .reset  (reset),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   fetch_address fetch_address_i (
      .hcount    (hcount),
      .vcount    (vcount),
      .slot      (slot),
      .read_addr (read_addr)
   );

   // --------------------
   // banks and display
   // --------------------
   bank_arbiter bank_arbiter_i (
      .slot        (slot),
      .read_addr   (read_addr),
      .cam_addr    (cam_addr),
      .cam_data    (cam_data),
      .proc_addr   (proc_addr),
      .proc_data   (proc_data),
      .proc_enable (proc_enable),
      .show_proc   (show_proc),
      .bank0_rdata (bank0_rdata),
      .bank1_rdata (bank1_rdata),
      .bank0_addr  (bank0_addr),
      .bank0_we    (bank0_we),
      .bank0_wdata (bank0_wdata),
      .bank1_addr  (bank1_addr),
      .bank1_we    (bank1_we),
      .bank1_wdata (bank1_wdata),
      .read_word   (read_word)
   );

   pixel_unpack pixel_unpack_i (
      .clk       (clk),
      .reset     (reset),
      .slot      (slot),
      .read_word (read_word),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .vga_red   (vga_red),
      .vga_green (vga_green),
      .vga_blue  (vga_blue),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_blank (vga_blank)
   );

endmodule

`default_nettype wire

// ==== testbench/zbt_bank_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module zbt_bank_model import video_pkg::*; (
   input  logic       clk,
   input  vram_addr_t addr,
   input  logic       we,
   input  vram_word_t wdata,
   output vram_word_t rdata
);

   // whole address space of one bank
   vram_word_t mem [0:(1<<19)-1];

   // first read stage, the second one is rdata itself
   vram_word_t rd_stage;

   // --------------------
   // synchronous port
   // --------------------
   // address, we and write data are taken at the same edge
   // read data shows up two edges after its address
   always @(posedge clk) begin
      if (we === 1'b1) begin
         mem[addr] <= wdata;
      end
      // old content on a same-cycle write
      rd_stage <= mem[addr];
      rdata    <= rd_stage;
   end

   // --------------------
   // direct fill
   // --------------------
   // sets one word at once, outside of any bus cycle
   task automatic preload(input vram_addr_t a, input vram_word_t d);
      mem[a] = d;
   endtask

endmodule

`default_nettype wire

// ==== testbench/tb_zbt_video.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module tb_zbt_video import video_pkg::*; ();

   logic       clk;
   logic       reset;
   vram_addr_t cam_addr;
   vram_word_t cam_data;
   vram_addr_t proc_addr;
   vram_word_t proc_data;
   logic       proc_enable;
   logic       show_proc;
   vram_word_t bank0_rdata;
   vram_word_t bank1_rdata;
   vram_addr_t bank0_addr;
   logic       bank0_we;
   vram_word_t bank0_wdata;
   vram_addr_t bank1_addr;
   logic       bank1_we;
   vram_word_t bank1_wdata;
   logic [7:0] vga_red;
   logic [7:0] vga_green;
   logic [7:0] vga_blue;
   logic       vga_hsync;
   logic       vga_vsync;
   logic       vga_blank;

   // raster position as followed by the testbench
   int   cur_h;
   int   cur_v;
   // levels applied at the next falling edge
   logic en_req;
   logic show_req;
   // keep writes on line 1023 that the display never reads
   logic park_writes;
   int   error_count;
   int   test_count;
   int   test_start_errors;

   zbt_video_top zbt_video_top_i (
      .clk (clk), .reset (reset),
      .cam_addr (cam_addr), .cam_data (cam_data),
      .proc_addr (proc_addr), .proc_data (proc_data),
      .proc_enable (proc_enable), .show_proc (show_proc),
      .bank0_rdata (bank0_rdata), .bank1_rdata (bank1_rdata),
      .bank0_addr (bank0_addr), .bank0_we (bank0_we), .bank0_wdata (bank0_wdata),
      .bank1_addr (bank1_addr), .bank1_we (bank1_we), .bank1_wdata (bank1_wdata),
      .vga_red (vga_red), .vga_green (vga_green), .vga_blue (vga_blue),
      .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_blank (vga_blank)
   );

   zbt_bank_model bank0_model (
      .clk (clk), .addr (bank0_addr), .we (bank0_we), .wdata (bank0_wdata),
      .rdata (bank0_rdata)
   );

   zbt_bank_model bank1_model (
      .clk (clk), .addr (bank1_addr), .we (bank1_we), .wdata (bank1_wdata),
      .rdata (bank1_rdata)
   );

   // 4 ns period
   always #2 clk = ~clk;

   // --------------------
   // expected values
   // --------------------
   // line on top and column / 2 below
   function automatic vram_addr_t word_addr(input int line, input int col);
      vram_addr_t a;
      a[18:9] = line[9:0];
      a[8:0]  = col[9:1];
      return a;
   endfunction

   // address formed during count h of line v
   // from the hsync point on the next line is fetched
   function automatic vram_addr_t forecast_addr(input int h, input int v);
      int col;
      int line;
      if (h >= `H_SYNC_ON) begin
         col  = h - `H_SYNC_ON;
         line = (v + 1) % `V_TOTAL;
      end else begin
         col  = h + `FETCH_LEAD;
         line = v;
      end
      return word_addr(line, col);
   endfunction

   // fill pattern that differs per bank and uses every address bit
   function automatic vram_word_t fill_word(input int bank, input vram_addr_t a);
      logic [17:0] hi;
      logic [17:0] lo;
      hi = {a[8:0], a[18:10]} ^ ((bank == 1) ? 18'h31c6e : 18'h0a5f3);
      lo = a[17:0] ^ ((bank == 1) ? 18'h0f0f0 : 18'h3c0c3);
      return {hi, lo};
   endfunction

   // --------------------
   // reporting
   // --------------------
   task automatic report_error(input string msg);
      error_count++;
      $display("FAIL %0t: %s", $time, msg);
   endtask

   task automatic timeout_abort(input string what);
      $display("timeout: no %s within the cycle limit", what);
      $display("Done: errors found");
      $finish;
   endtask

   task automatic begin_test();
      test_start_errors = error_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("%s: %0d errors", name, error_count - test_start_errors);
   endtask

   // --------------------
   // cycle stepping
   // --------------------
   // on the falling edge follow the count, drive new inputs and let them settle
   task automatic next_cycle();
      logic [63:0] r;
      @(negedge clk);
      cur_h = cur_h + 1;
      if (cur_h == `H_TOTAL) begin
         cur_h = 0;
         cur_v = (cur_v + 1) % `V_TOTAL;
      end
      proc_enable = en_req;
      show_proc   = show_req;
      r = {$urandom, $urandom};
      cam_data  = r[35:0];
      cam_addr  = r[54:36];
      r = {$urandom, $urandom};
      proc_data = r[35:0];
      proc_addr = r[54:36];
      if (park_writes) begin
         cam_addr[18:9]  = 10'h3ff;
         proc_addr[18:9] = 10'h3ff;
      end
      #1;
   endtask

   task automatic wait_for_position(input int h, input int v, input int limit);
      int n;
      n = 0;
      while (!(cur_h == h && cur_v == v)) begin
         if (n == limit) begin
            timeout_abort("raster position reached");
         end
         next_cycle();
         n++;
      end
   endtask

   // first low cycle of vga_hsync is count H_SYNC_ON + 1
   task automatic align_to_hsync();
      int n;
      n = 0;
      while (vga_hsync !== 1'b0) begin
         if (n == 2 * `H_TOTAL) begin
            timeout_abort("falling edge on vga_hsync");
         end
         next_cycle();
         n++;
      end
      if (cur_h != `H_SYNC_ON + 1) begin
         report_error($sformatf("hsync fell at count %0d", cur_h));
      end
      cur_h = `H_SYNC_ON + 1;
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_reset_and_timing();
      int line_i;
      int i;
      int next_v;
      int hs_low;
      int blank_low;
      int vs_low;
      int exp_blank;
      begin_test();
      if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_blank !== 1'b0) begin
         report_error("vga syncs or blank wrong after reset");
      end
      if (bank0_we !== 1'b0 || bank1_we !== 1'b0) begin
         report_error("bank we high after reset");
      end
      align_to_hsync();
      vs_low = 0;
      // one window per line from one hsync fall to the next
      for (line_i = 0; line_i < `V_TOTAL; line_i++) begin
         next_v    = (cur_v + 1) % `V_TOTAL;
         hs_low    = 0;
         blank_low = 0;
         for (i = 0; i < `H_TOTAL; i++) begin
            hs_low    += (vga_hsync === 1'b0);
            blank_low += (vga_blank === 1'b0);
            vs_low    += (vga_vsync === 1'b0);
            next_cycle();
         end
         exp_blank = (next_v < `V_ACTIVE) ? `H_ACTIVE : 0;
         if (vga_hsync !== 1'b0 || hs_low != `H_SYNC_OFF - `H_SYNC_ON) begin
            report_error($sformatf("hsync period or width wrong, %0d low", hs_low));
         end
         if (blank_low != exp_blank) begin
            report_error($sformatf("line %0d blank low %0d", next_v, blank_low));
         end
      end
      if (vs_low != (`V_SYNC_OFF - `V_SYNC_ON) * `H_TOTAL) begin
         report_error($sformatf("vsync low for %0d cycles", vs_low));
      end
      end_test("reset and raster timing");
   endtask

   task automatic test_bank0_writes();
      int i;
      begin_test();
      for (i = 0; i < 400; i++) begin
         next_cycle();
         // odd counts are write slots
         if (bank0_we !== cur_h[0]) begin
            report_error($sformatf("bank0_we %b at count %0d", bank0_we, cur_h));
         end
         if (cur_h[0] && (bank0_addr !== cam_addr || bank0_wdata !== cam_data)) begin
            report_error($sformatf("bank0 write mismatch at count %0d", cur_h));
         end
      end
      end_test("bank 0 writes");
   endtask

   task automatic test_bank1_gating();
      int i;
      begin_test();
      en_req = 1'b0;
      for (i = 0; i < 200; i++) begin
         next_cycle();
         if (bank1_we !== 1'b0) begin
            report_error("bank1_we high with proc_enable low");
         end
      end
      en_req = 1'b1;
      for (i = 0; i < 200; i++) begin
         next_cycle();
         if (bank1_we !== cur_h[0] || bank1_we !== bank0_we) begin
            report_error($sformatf("bank1_we %b at count %0d", bank1_we, cur_h));
         end
         if (cur_h[0] && (bank1_addr !== proc_addr || bank1_wdata !== proc_data)) begin
            report_error($sformatf("bank1 write mismatch at count %0d", cur_h));
         end
      end
      end_test("bank 1 write gating");
   endtask

   // runs across the frame wrap from line 805 into line 1
   task automatic test_read_addresses();
      int i;
      vram_addr_t exp_addr;
      begin_test();
      wait_for_position(1000, `V_TOTAL - 1, 2 * `H_TOTAL * `V_TOTAL);
      for (i = 0; i < 2 * `H_TOTAL; i++) begin
         next_cycle();
         if (!cur_h[0]) begin
            exp_addr = forecast_addr(cur_h, cur_v);
            if (bank0_addr !== exp_addr || bank1_addr !== exp_addr) begin
               report_error($sformatf("read addr %h/%h, expected %h at %0d/%0d",
                  bank0_addr, bank1_addr, exp_addr, cur_v, cur_h));
            end
         end
      end
      end_test("read addresses");
   endtask

   task automatic test_display(input int bank);
      int target;
      int w;
      int i;
      int col;
      vram_addr_t a;
      vram_word_t word;
      logic [17:0] pix;
      begin_test();
      park_writes = 1'b1;
      en_req      = 1'b1;
      show_req    = (bank == 1);
      next_cycle();
      // a visible line far enough ahead that none of it is fetched yet
      target = (cur_v + 2) % `V_TOTAL;
      if (target >= `V_ACTIVE) begin
         target = 0;
      end
      for (w = 0; w < `H_ACTIVE / 2; w++) begin
         a = word_addr(target, 2 * w);
         bank0_model.preload(a, fill_word(0, a));
         bank1_model.preload(a, fill_word(1, a));
      end
      wait_for_position(0, target, 2 * `H_TOTAL * `V_TOTAL);
      // counts 0 to 1020 show columns up to 1023
      for (i = 0; i <= `H_ACTIVE - 4; i++) begin
         // counts 0 to 4 still carry words fetched before the line began
         if (cur_h >= 5) begin
            col  = cur_h + 3;
            word = fill_word(bank, word_addr(target, col));
            pix  = (col % 2 == 0) ? word[35:18] : word[17:0];
            if (vga_red !== {pix[17:12], 2'b00} || vga_green !== {pix[11:6], 2'b00} ||
                vga_blue !== {pix[5:0], 2'b00}) begin
               report_error($sformatf("pixel %h %h %h at count %0d, expected %h",
                  vga_red, vga_green, vga_blue, cur_h, pix));
            end
         end
         next_cycle();
      end
      park_writes = 1'b0;
      end_test($sformatf("display from bank %0d", bank));
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      int unsigned seed_value;
      clk         = 1'b0;
      reset       = 1'b1;
      cam_addr    = '0;
      cam_data    = '0;
      proc_addr   = '0;
      proc_data   = '0;
      proc_enable = 1'b0;
      show_proc   = 1'b0;
      en_req      = 1'b0;
      show_req    = 1'b0;
      park_writes = 1'b0;
      error_count = 0;
      test_count  = 0;
      cur_h       = 0;
      cur_v       = 0;
      seed_value  = $urandom(32'ha0d3);
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #1;
      // counters still hold line 0 and count 0
      cur_h = 0;
      cur_v = 0;
      test_reset_and_timing();
      test_bank0_writes();
      test_bank1_gating();
      test_read_addresses();
      test_display(0);
      test_display(1);
      $display("tests run %0d, errors %0d", test_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/raster_timing.sv
hdl/fetch_address.sv
hdl/bank_arbiter.sv
hdl/pixel_unpack.sv
hdl/zbt_video_top.sv
testbench/zbt_bank_model.sv
testbench/tb_zbt_video.sv
